/* files.f */
+incdir+src
src/geom_pkg.sv
src/pixel_pkg.sv
src/tri_store.sv
src/edge_test_pipe.sv
src/hit_select.sv
src/pixel_writer.sv
src/int_wrap.sv
test/int_wrap_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the intersection testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f files.f \
  --top-module int_wrap_tb \
  -Mdir obj_dir

./obj_dir/Vint_wrap_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* src/edge_test_pipe.sv */
// three-stage edge-function test for two triangles at the ray point
// stage 1 differences, stage 2 cross products, stage 3 sign and depth rule
// both windings count as inside

`default_nettype none

`include "rt_defines.svh"

module edge_test_pipe
  import geom_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      stall,
  input  logic      in_valid,
  input  ray_t      ray,
  input  triangle_t tri_0,
  input  triangle_t tri_1,
  output logic      out_valid,
  output ray_id_t   out_ray_id,
  output logic      hit0,
  output logic      hit1,
  output depth_t    depth0,
  output depth_t    depth1
);

  localparam int DW = `RT_COORD_W + 1; // difference width
  localparam int PW = 2 * DW + 1;      // cross product width

  triangle_t tri_in [2];
  vertex_t   vtx [2][3];

  logic                 s1_valid;
  ray_id_t              s1_id;
  logic [1:0]           s1_near;        // depth <= t_max per triangle
  depth_t               s1_depth [2];
  logic signed [DW-1:0] s1_ex [2][3];   // edge vector a->b
  logic signed [DW-1:0] s1_ey [2][3];
  logic signed [DW-1:0] s1_qx [2][3];   // point relative to a
  logic signed [DW-1:0] s1_qy [2][3];

  logic                 s2_valid;
  ray_id_t              s2_id;
  logic [1:0]           s2_near;
  depth_t               s2_depth [2];
  logic signed [PW-1:0] s2_e [2][3];    // edge function values

  logic [1:0] all_pos;
  logic [1:0] all_neg;

  assign tri_in[0] = tri_0;
  assign tri_in[1] = tri_1;

  always_comb begin
    for (int t = 0; t < 2; t++) begin
      vtx[t][0] = tri_in[t].v0;
      vtx[t][1] = tri_in[t].v1;
      vtx[t][2] = tri_in[t].v2;
    end
  end

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid  <= in_valid;
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  // stage 1, six edges at once
  always_ff @(posedge clk) begin
    if (!stall) begin
      s1_id <= ray.id;
      for (int t = 0; t < 2; t++) begin
        s1_depth[t] <= tri_in[t].depth;
        s1_near[t]  <= (tri_in[t].depth <= ray.t_max); // early miss folded in
        for (int k = 0; k < 3; k++) begin
          s1_ex[t][k] <= DW'(vtx[t][(k + 1) % 3].x) - DW'(vtx[t][k].x);
          s1_ey[t][k] <= DW'(vtx[t][(k + 1) % 3].y) - DW'(vtx[t][k].y);
          s1_qx[t][k] <= DW'(ray.px) - DW'(vtx[t][k].x);
          s1_qy[t][k] <= DW'(ray.py) - DW'(vtx[t][k].y);
        end
      end
    end
  end

  // stage 2, cross products
  always_ff @(posedge clk) begin
    if (!stall) begin
      s2_id    <= s1_id;
      s2_near  <= s1_near;
      s2_depth <= s1_depth;
      for (int t = 0; t < 2; t++) begin
        for (int k = 0; k < 3; k++) begin
          s2_e[t][k] <= PW'(s1_ex[t][k]) * PW'(s1_qy[t][k])
                      - PW'(s1_ey[t][k]) * PW'(s1_qx[t][k]);
        end
      end
    end
  end

  // sign agreement, zero counts for either side
  always_comb begin
    for (int t = 0; t < 2; t++) begin
      all_pos[t] = 1'b1;
      all_neg[t] = 1'b1;
      for (int k = 0; k < 3; k++) begin
        all_pos[t] = all_pos[t] & !s2_e[t][k][PW-1];
        all_neg[t] = all_neg[t] & (s2_e[t][k][PW-1] || (s2_e[t][k] == '0));
      end
    end
  end

  // stage 3
  always_ff @(posedge clk) begin
    if (!stall) begin
      out_ray_id <= s2_id;
      hit0       <= s2_near[0] && (all_pos[0] || all_neg[0]);
      hit1       <= s2_near[1] && (all_pos[1] || all_neg[1]);
      depth0     <= s2_depth[0];
      depth1     <= s2_depth[1];
    end
  end

  a_valid_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(out_valid));

endmodule

`default_nettype wire

/* src/geom_pkg.sv */
// geometry types: coordinates, vertices, triangles, rays
// and the four-phase port state enum

`default_nettype none

`include "rt_defines.svh"

package geom_pkg;

  typedef logic signed [`RT_COORD_W-1:0] coord_t;
  typedef logic [`RT_DEPTH_W-1:0] depth_t;
  typedef logic [`RT_RAYID_W-1:0] ray_id_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } vertex_t; // 24 bits

  typedef struct packed {
    vertex_t                 v0;
    vertex_t                 v1;
    vertex_t                 v2;
    depth_t                  depth; // flat, one depth per triangle
    logic [`RT_COLOR_W-1:0]  color;
  } triangle_t; // 112 bits

  // ray cast along z through (px, py)
  typedef struct packed {
    coord_t  px;
    coord_t  py;
    depth_t  t_max;
    ray_id_t id;
  } ray_t; // 48 bits

  // req/ack port states
  typedef enum logic [1:0] {
    IDLE,
    ACK,
    WAIT_DROP
  } load_state_t;

endpackage

`default_nettype wire

/* src/hit_select.sv */
// nearest-hit choice between the two triangles
// color lookup and the registered pixel entry, stage 4

`default_nettype none

`include "rt_defines.svh"

module hit_select
  import geom_pkg::*;
  import pixel_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         stall,
  input  logic         in_valid,
  input  ray_id_t      in_ray_id,
  input  logic         hit0,
  input  logic         hit1,
  input  depth_t       depth0,
  input  depth_t       depth1,
  input  color_t       tri0_color,
  input  color_t       tri1_color,
  output logic         out_valid,
  output pixel_entry_t out_entry
);

  hit_src_t src;
  color_t   color_sel;

  always_comb begin
    if (hit0 && hit1) src = (depth1 < depth0) ? TRI1 : TRI0; // tie -> tri 0
    else if (hit0)    src = TRI0;
    else if (hit1)    src = TRI1;
    else              src = MISS;
  end

  always_comb begin
    unique case (src)
      TRI0:    color_sel = tri0_color;
      TRI1:    color_sel = tri1_color;
      default: color_sel = `RT_COLOR_MISS; // background
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)         out_valid <= 1'b0;
    else if (!stall) out_valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      out_entry.color  <= color_sel;
      out_entry.ray_id <= in_ray_id; // id rides along
    end
  end

endmodule

`default_nettype wire

/* src/int_wrap.sv */
// top of the intersection subsystem
// ray req/ack intake, triangle store, edge test pipe,
// hit select and pixel writer

`default_nettype none

module int_wrap
  import geom_pkg::*;
  import pixel_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         tri_req,
  input  logic         tri_slot,
  input  triangle_t    tri_data,
  output logic         tri_ack,
  input  logic         ray_req,
  input  ray_t         ray_in,
  output logic         ray_ack,
  output logic         we,
  input  logic         full,
  output pixel_entry_t pixel_entry
);

  triangle_t    tri_0;
  triangle_t    tri_1;
  load_state_t  ray_state;
  logic         ray_accept;
  logic         stall;
  logic         e_valid;
  ray_id_t      e_ray_id;
  logic         hit0;
  logic         hit1;
  depth_t       depth0;
  depth_t       depth1;
  logic         h_valid;
  pixel_entry_t h_entry;

  // ray_in is held by the requester, so stage 1 samples it on the accept edge
  assign ray_accept = (ray_state == IDLE) && ray_req && !stall;
  assign ray_ack    = (ray_state != IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      ray_state <= IDLE;
    end else begin
      unique case (ray_state)
        IDLE:      if (ray_accept) ray_state <= ACK;
        ACK:       ray_state <= WAIT_DROP;
        WAIT_DROP: if (!ray_req) ray_state <= IDLE;
        default:   ray_state <= IDLE;
      endcase
    end
  end

  tri_store tri_store_inst (
    .clk      (clk),
    .rst      (rst),
    .tri_req  (tri_req),
    .tri_slot (tri_slot),
    .tri_data (tri_data),
    .tri_ack  (tri_ack),
    .tri_0    (tri_0),
    .tri_1    (tri_1)
  );

  edge_test_pipe edge_test_pipe_inst (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .in_valid   (ray_accept), // one-cycle pulse per ray
    .ray        (ray_in),
    .tri_0      (tri_0),
    .tri_1      (tri_1),
    .out_valid  (e_valid),
    .out_ray_id (e_ray_id),
    .hit0       (hit0),
    .hit1       (hit1),
    .depth0     (depth0),
    .depth1     (depth1)
  );

  hit_select hit_select_inst (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .in_valid   (e_valid),
    .in_ray_id  (e_ray_id),
    .hit0       (hit0),
    .hit1       (hit1),
    .depth0     (depth0),
    .depth1     (depth1),
    .tri0_color (tri_0.color),
    .tri1_color (tri_1.color),
    .out_valid  (h_valid),
    .out_entry  (h_entry)
  );

  pixel_writer pixel_writer_inst (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (h_valid),
    .in_entry    (h_entry),
    .full        (full),
    .we          (we),
    .pixel_entry (pixel_entry),
    .stall       (stall) // freezes every stage and the intake
  );

endmodule

`default_nettype wire

/* src/pixel_pkg.sv */
// output side types: color, pixel buffer entry
// and the hit source enum

`default_nettype none

`include "rt_defines.svh"

package pixel_pkg;

  import geom_pkg::*;

  typedef logic [`RT_COLOR_W-1:0] color_t;

  typedef struct packed {
    color_t  color;  // upper 24 bits
    ray_id_t ray_id; // lower 8 bits
  } pixel_entry_t;

  // which triangle colors the pixel
  typedef enum logic [1:0] {
    MISS,
    TRI0,
    TRI1
  } hit_src_t;

endpackage

`default_nettype wire

/* src/pixel_writer.sv */
// pixel buffer output register
// we/full back-pressure and the pipe-wide stall

`default_nettype none

module pixel_writer
  import pixel_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         in_valid,
  input  pixel_entry_t in_entry,
  input  logic         full,
  output logic         we,
  output pixel_entry_t pixel_entry,
  output logic         stall
);

  // entry pending and buffer cannot take it
  assign stall = we && full;

  // we stays up until the entry is taken
  always_ff @(posedge clk) begin
    if (rst) begin
      we <= 1'b0;
    end else if (!stall) begin
      we <= in_valid; // next entry or idle
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && in_valid) begin
      pixel_entry <= in_entry;
    end
  end

  // entry queued behind the held one waits unchanged upstream
  a_hold_on_full: assert property (@(posedge clk) disable iff (rst)
    stall && in_valid |=> in_valid && $stable(in_entry));

endmodule

`default_nettype wire

/* src/rt_defines.svh */
// widths and constants for the ray-triangle intersection unit
// coordinate, depth, ray id and color widths
// background color and ray-to-we latency

`ifndef RT_DEFINES_SVH
`define RT_DEFINES_SVH

// signed fixed-point screen coordinate
`define RT_COORD_W 12

// unsigned depth, also used for ray t_max
`define RT_DEPTH_W 16

`define RT_RAYID_W 8 // one pixel entry per ray id

// 8 bits per channel, rgb
`define RT_COLOR_W 24

// background for rays that hit nothing
`define RT_COLOR_MISS 24'h112233

// ray_ack rise to we rise, no back-pressure
`define RT_PIPE_LAT 4

`endif

/* src/tri_store.sv */
// two-slot triangle register file
// loaded over a four-phase req/ack port, one triangle per handshake

`default_nettype none

module tri_store
  import geom_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      tri_req,
  input  logic      tri_slot,
  input  triangle_t tri_data,
  output logic      tri_ack,
  output triangle_t tri_0,
  output triangle_t tri_1
);

  load_state_t state;
  logic        load;

  assign load    = (state == IDLE) && tri_req; // write on first req cycle
  assign tri_ack = (state != IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      unique case (state)
        IDLE:      if (tri_req) state <= ACK;
        ACK:       state <= WAIT_DROP; // ack held at least one cycle
        WAIT_DROP: if (!tri_req) state <= IDLE; // ack falls next edge
        default:   state <= IDLE;
      endcase
    end
  end

  // slot registers
  always_ff @(posedge clk) begin
    if (rst) begin
      tri_0 <= '0;
      tri_1 <= '0;
    end else if (load) begin
      if (tri_slot) tri_1 <= tri_data;
      else          tri_0 <= tri_data;
    end
  end

  // requester keeps data steady until it sees ack
  a_data_stable: assert property (@(posedge clk) disable iff (rst)
    tri_req && !tri_ack |=> $stable(tri_data));

endmodule

`default_nettype wire

/* test/int_wrap_tb.sv */
// testbench for the ray-triangle intersection top level
// req/ack drivers, reference model, expected-entry queue and monitor
// directed tests: load, hit/miss, overlap, t_max, back-pressure, latency

`default_nettype none

`include "rt_defines.svh"

module int_wrap_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import geom_pkg::*;
  import pixel_pkg::*;

  localparam int RAYS_MAX       = 80; // upper bound over all tests
  localparam int CYCLES_PER_RAY = 25; // handshake, pipe and random stalls
  localparam int TIMEOUT_CYCLES = RAYS_MAX * CYCLES_PER_RAY;

  logic         clk;
  logic         rst;
  logic         tri_req;
  logic         tri_slot;
  triangle_t    tri_data;
  logic         tri_ack;
  logic         ray_req;
  ray_t         ray_in;
  logic         ray_ack;
  logic         we;
  logic         full;
  pixel_entry_t pixel_entry;

  triangle_t    tb_tri [2];      // what the store should hold
  pixel_entry_t exp_q [$];       // expected entries, in ray order
  pixel_entry_t exp_e;
  pixel_entry_t held_entry;
  logic         hold_valid = 1'b0;
  logic         ack_last = 1'b0;
  logic         we_last = 1'b0;
  logic         rand_full = 1'b0; // random back-pressure on/off
  ray_id_t      next_id = '0;
  color_t       last_color;
  int           cycles = 0;
  int           ack_rise_cycle = 0;
  int           we_rise_cycle = 0;
  int           n_errors = 0;
  int           n_checks = 0;
  int           n_tests = 0;
  int           n_sent = 0;
  int           n_taken = 0;

  int_wrap int_wrap_inst (
    .clk(clk), .rst(rst),
    .tri_req(tri_req), .tri_slot(tri_slot), .tri_data(tri_data), .tri_ack(tri_ack),
    .ray_req(ray_req), .ray_in(ray_in), .ray_ack(ray_ack),
    .we(we), .full(full), .pixel_entry(pixel_entry)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  // cycle count and run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run passed %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // full from the pixel buffer side
  initial begin
    full = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      full = rand_full && ($urandom_range(1, 0) == 1);
    end
  end

  task automatic check_entry(input pixel_entry_t got, input pixel_entry_t want,
                             input string what);
    n_checks++;
    if (got !== want) begin
      $display("Error at %0t: %s got color %h id %0d, expected color %h id %0d",
               $time, what, got.color, got.ray_id, want.color, want.ray_id);
      n_errors++;
    end
  endtask

  task automatic check_color(input color_t got, input color_t want, input string what);
    n_checks++;
    if (got !== want) begin
      $display("Error at %0t: %s got %h, expected %h", $time, what, got, want);
      n_errors++;
    end
  endtask

  task automatic check_int(input int got, input int want, input string what);
    n_checks++;
    if (got != want) begin
      $display("Error at %0t: %s got %0d, expected %0d", $time, what, got, want);
      n_errors++;
    end
  endtask

  // sampled mid-cycle, where outputs and full are settled
  always @(negedge clk) begin
    if (!rst) begin
      if (ray_ack && !ack_last) ack_rise_cycle = cycles;
      if (we && !we_last) we_rise_cycle = cycles;
      ack_last = ray_ack;
      we_last  = we;
      if (hold_valid) check_entry(pixel_entry, held_entry, "entry under full");
      hold_valid = we && full;
      held_entry = pixel_entry;
      if (we && !full) begin // taken on the coming edge
        n_taken++;
        if (exp_q.size() == 0) begin
          $display("pixel entry written with no ray outstanding at %0t", $time);
          n_errors++;
        end else begin
          exp_e = exp_q.pop_front();
          check_entry(pixel_entry, exp_e, "taken entry");
          last_color = pixel_entry.color;
        end
      end
    end
  end

  function automatic triangle_t make_tri(input int x0, input int y0, input int x1,
                                         input int y1, input int x2, input int y2,
                                         input int depth, input color_t color);
    triangle_t t;
    t.v0.x  = coord_t'(x0);
    t.v0.y  = coord_t'(y0);
    t.v1.x  = coord_t'(x1);
    t.v1.y  = coord_t'(y1);
    t.v2.x  = coord_t'(x2);
    t.v2.y  = coord_t'(y2);
    t.depth = depth_t'(depth);
    t.color = color;
    return t;
  endfunction

  // inside if no edge value has the opposite sign, then depth within t_max
  function automatic logic ray_hits(input triangle_t t, input ray_t r);
    int   xs [3];
    int   ys [3];
    int   e;
    logic pos;
    logic neg;
    xs[0] = int'(t.v0.x);
    ys[0] = int'(t.v0.y);
    xs[1] = int'(t.v1.x);
    ys[1] = int'(t.v1.y);
    xs[2] = int'(t.v2.x);
    ys[2] = int'(t.v2.y);
    pos = 1'b1;
    neg = 1'b1;
    for (int k = 0; k < 3; k++) begin
      e = (xs[(k + 1) % 3] - xs[k]) * (int'(r.py) - ys[k])
        - (ys[(k + 1) % 3] - ys[k]) * (int'(r.px) - xs[k]);
      if (e < 0) pos = 1'b0;
      if (e > 0) neg = 1'b0;
    end
    return (pos || neg) && (t.depth <= r.t_max);
  endfunction

  function automatic pixel_entry_t model_entry(input ray_t r);
    pixel_entry_t e;
    logic         h0;
    logic         h1;
    h0 = ray_hits(tb_tri[0], r);
    h1 = ray_hits(tb_tri[1], r);
    e.ray_id = r.id;
    if (h0 && (!h1 || tb_tri[0].depth <= tb_tri[1].depth)) e.color = tb_tri[0].color;
    else if (h1) e.color = tb_tri[1].color; // nearer, or the only hit
    else e.color = `RT_COLOR_MISS;
    return e;
  endfunction

  task automatic load_tri(input logic slot, input triangle_t t);
    tb_tri[slot] = t;
    tri_slot = slot;
    tri_data = t;
    tri_req  = 1'b1;
    @(posedge clk);
    #1;
    check_int(int'(tri_ack), 1, "tri_ack one cycle after tri_req");
    tri_req = 1'b0;
    while (tri_ack) begin // four-phase, wait for ack to fall
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_ray(input int px, input int py, input int t_max);
    ray_t r;
    r.px    = coord_t'(px);
    r.py    = coord_t'(py);
    r.t_max = depth_t'(t_max);
    r.id    = next_id;
    next_id = next_id + 8'd1;
    exp_q.push_back(model_entry(r));
    n_sent++;
    ray_in  = r;
    ray_req = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!ray_ack); // held off while stalled
    ray_req = 1'b0;
    while (ray_ack) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_test(input string name, input int errs0);
    n_tests++;
    $display("%s: %0d errors", name, n_errors - errs0);
  endtask

  task automatic load_test();
    int errs0 = n_errors;
    load_tri(1'b0, make_tri(0, 0, 100, 0, 0, 100, 50, 24'hAA0000)); // ccw
    load_tri(1'b1, make_tri(20, 20, 20, 200, 200, 20, 30, 24'h00BB00)); // cw
    send_ray(5, 5, 'hFFFF);
    wait_drain();
    check_color(last_color, tb_tri[0].color, "color after slot 0 load");
    send_ray(150, 30, 'hFFFF);
    wait_drain();
    check_color(last_color, tb_tri[1].color, "color after slot 1 load");
    finish_test("triangle load", errs0);
  endtask

  task automatic hit_miss_test();
    int errs0 = n_errors;
    send_ray(5, 5, 'hFFFF);     // tri 0 only
    send_ray(150, 30, 'hFFFF);  // tri 1 only, cw winding
    send_ray(-50, -50, 'hFFFF); // miss
    send_ray(300, 300, 'hFFFF);
    send_ray(0, 50, 'hFFFF);    // on a tri 0 edge
    wait_drain();
    finish_test("hit and miss", errs0);
  endtask

  task automatic overlap_test();
    int errs0 = n_errors;
    send_ray(30, 30, 'hFFFF); // tri 1 nearer
    wait_drain();
    load_tri(1'b1, make_tri(20, 20, 20, 200, 200, 20, 50, 24'h00BB00));
    send_ray(30, 30, 'hFFFF); // equal depth goes to tri 0
    wait_drain();
    load_tri(1'b1, make_tri(20, 20, 20, 200, 200, 20, 80, 24'h00BB00));
    send_ray(30, 30, 'hFFFF);
    wait_drain();
    finish_test("overlap", errs0);
  endtask

  task automatic tmax_test();
    int errs0 = n_errors;
    load_tri(1'b1, make_tri(20, 20, 20, 200, 200, 20, 30, 24'h00BB00));
    send_ray(30, 30, 40);  // tri 0 beyond t_max, falls to tri 1
    send_ray(30, 30, 20);  // both beyond
    send_ray(5, 5, 49);
    send_ray(5, 5, 50);    // depth equal to t_max still hits
    send_ray(150, 30, 29);
    wait_drain();
    finish_test("t_max rejection", errs0);
  endtask

  task automatic backpressure_test();
    int errs0 = n_errors;
    int sent0 = n_sent;
    int taken0 = n_taken;
    int tm;
    rand_full = 1'b1;
    for (int i = 0; i < 40; i++) begin
      case ($urandom_range(3, 0))
        0:       tm = 20;
        1:       tm = 40;
        2:       tm = 60;
        default: tm = 'hFFFF;
      endcase
      send_ray(int'($urandom_range(300, 0)) - 50, int'($urandom_range(300, 0)) - 50, tm);
    end
    wait_drain();
    rand_full = 1'b0;
    repeat (`RT_PIPE_LAT + 2) @(posedge clk); // room for a stray extra entry
    #1;
    check_int(n_taken - taken0, n_sent - sent0, "entries per ray under back-pressure");
    finish_test("back-pressure", errs0);
  endtask

  task automatic latency_test();
    int errs0 = n_errors;
    @(posedge clk); // let full settle low
    #1;
    send_ray(5, 5, 'hFFFF);
    wait_drain();
    check_int(we_rise_cycle - ack_rise_cycle, `RT_PIPE_LAT, "ray_ack to we latency");
    finish_test("latency", errs0);
  endtask

  initial begin
    void'($urandom(92));
    rst      = 1'b1;
    tri_req  = 1'b0;
    tri_slot = 1'b0;
    tri_data = '0;
    ray_req  = 1'b0;
    ray_in   = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    load_test();
    hit_miss_test();
    overlap_test();
    tmax_test();
    backpressure_test();
    latency_test();
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
